/* tb.f */
logic/gb_pkg.sv
logic/frame_scan.sv
logic/stencil_pipe.sv
logic/spec_blur.sv
logic/replay_fsm.sv
logic/beat_fifo.sv
logic/eq_check.sv
logic/gb_eq_top.sv
sim/gb_eq_asserts.sv
sim/tb_gb_eq.sv

/* Bender.yml */
package:
  name: gb_eq

sources:
  - files:
      - logic/gb_pkg.sv
      - logic/frame_scan.sv
      - logic/stencil_pipe.sv
      - logic/spec_blur.sv
      - logic/replay_fsm.sv
      - logic/beat_fifo.sv
      - logic/eq_check.sv
      - logic/gb_eq_top.sv
  - target: test
    files:
      - sim/gb_eq_asserts.sv
      - sim/tb_gb_eq.sv

/* sim/tb_gb_eq.sv */
// gaussian blur equivalence testbench
module tb_gb_eq;

    import gb_pkg::*;

    localparam int NPIX = IMG_H * IMG_W;
    localparam int NOUT = (IMG_H - 2) * (IMG_W - 2);

    logic       clk;
    logic       rst_init;
    logic       in_valid;
    pixel_t     in_pixel;
    logic       out_valid;
    blur_beat_t out_beat;
    logic       cmp_valid;
    logic       mismatch;
    logic [4:0] match_count;
    logic       frame_done;
    logic       overflow;

    pixel_t     img [NPIX];
    int         in_times [$];
    blur_beat_t got_beats [$];
    int         got_times [$];
    int         ncyc;
    int         cmp_seen;
    int         done_seen;
    int         errors;
    int         tests_run;
    int         tests_failed;

    gb_eq_top DUT (
        .clk         (clk),
        .rst_init    (rst_init),
        .in_valid    (in_valid),
        .in_pixel    (in_pixel),
        .out_valid   (out_valid),
        .out_beat    (out_beat),
        .cmp_valid   (cmp_valid),
        .mismatch    (mismatch),
        .match_count (match_count),
        .frame_done  (frame_done),
        .overflow    (overflow)
    );

    always #20 clk = ~clk;

    // sampled on the falling edge while inputs move on the rising one
    always @(negedge clk) begin
        ncyc = ncyc + 1;
        if (in_valid) begin
            in_times.push_back(ncyc);
        end
        if (out_valid) begin
            got_beats.push_back(out_beat);
            got_times.push_back(ncyc);
        end
        if (cmp_valid) begin
            cmp_seen = cmp_seen + 1;
        end
        if (frame_done) begin
            done_seen = done_seen + 1;
        end
    end

    task automatic report_value(input string name, input logic signed [31:0] got,
                                input int exp);
        $display("CHECK FAILED at time %0t: %s = %0d, expected %0d", $time, name, got, exp);
        errors++;
    endtask

    task automatic close_test(input string name, input int err_before);
        tests_run++;
        if (errors > err_before) begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - err_before);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // 1 2 1 / 2 4 2 / 1 2 1 over the sent image, divided by 16
    function automatic int blur_ref(input int cx, input int cy);
        int sum;
        int wt;
        sum = 0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                wt = ((dx == 0) ? 2 : 1) * ((dy == 0) ? 2 : 1);
                sum += wt * int'(img[(cy + dy) * IMG_W + cx + dx]);
            end
        end
        return sum / 16;
    endfunction

    task automatic fill_image(input bit flat, input int value);
        for (int k = 0; k < NPIX; k++) begin
            img[k] = flat ? pixel_t'(value) : pixel_t'($urandom_range(255, 0));
        end
    endtask

    task automatic send_pixel(input pixel_t p, input int gap);
        repeat (gap) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
        @(posedge clk);
        in_valid <= 1'b1;
        in_pixel <= p;
    endtask

    task automatic clear_logs();
        in_times.delete();
        got_beats.delete();
        got_times.delete();
        cmp_seen  = 0;
        done_seen = 0;
    endtask

    // sends img, waits for frame_done, checks the stream and the comparison
    task automatic run_frame(input int max_gap, input bit check_timing);
        int j;
        int x;
        int y;
        int wait_cnt;
        clear_logs();
        for (int k = 0; k < NPIX; k++) begin
            send_pixel(img[k], (max_gap > 0) ? $urandom_range(max_gap, 0) : 0);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        if (match_count !== 0) report_value("match_count at load end", match_count, 0);
        wait_cnt = 0;
        while (done_seen == 0 && wait_cnt < 400) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (done_seen == 0) begin
            $display("timeout: frame_done did not arrive within 400 cycles");
            errors++;
        end
        @(negedge clk);
        if (got_beats.size() != NOUT) report_value("out_valid count", got_beats.size(), NOUT);
        j = 0;
        for (int k = 0; k < NPIX && k < in_times.size(); k++) begin
            x = k % IMG_W;
            y = k / IMG_W;
            if (x >= 2 && y >= 2 && j < got_beats.size()) begin
                if (got_beats[j].pix !== blur_ref(x - 1, y - 1)) begin
                    report_value("out_beat.pix", got_beats[j].pix, blur_ref(x - 1, y - 1));
                end
                if (got_beats[j].pos.x !== x - 1) begin
                    report_value("out_beat.pos.x", got_beats[j].pos.x, x - 1);
                end
                if (got_beats[j].pos.y !== y - 1) begin
                    report_value("out_beat.pos.y", got_beats[j].pos.y, y - 1);
                end
                if (check_timing && got_times[j] != in_times[k] + 2) begin
                    report_value("out_valid latency", got_times[j] - in_times[k], 2);
                end
                j++;
            end
        end
        if (match_count !== NOUT) report_value("match_count", match_count, NOUT);
        if (cmp_seen != NOUT) report_value("cmp_valid count", cmp_seen, NOUT);
        if (mismatch !== 1'b0) report_value("mismatch", mismatch, 0);
        if (overflow !== 1'b0) report_value("overflow", overflow, 0);
    endtask

    task automatic idle_after_reset();
        int e0;
        e0 = errors;
        @(negedge clk);
        if (out_valid !== 1'b0) report_value("out_valid", out_valid, 0);
        if (cmp_valid !== 1'b0) report_value("cmp_valid", cmp_valid, 0);
        if (frame_done !== 1'b0) report_value("frame_done", frame_done, 0);
        if (mismatch !== 1'b0) report_value("mismatch", mismatch, 0);
        if (match_count !== 0) report_value("match_count", match_count, 0);
        close_test("after_reset", e0);
    endtask

    task automatic stream_back_to_back();
        int e0;
        e0 = errors;
        fill_image(1'b0, 0);
        run_frame(0, 1'b1);
        close_test("back_to_back", e0);
    endtask

    task automatic stream_with_gaps();
        int e0;
        e0 = errors;
        fill_image(1'b0, 0);
        run_frame(3, 1'b0);
        close_test("gapped", e0);
    endtask

    task automatic flat_second_frame();
        int e0;
        e0 = errors;
        fill_image(1'b1, 200);
        run_frame(1, 1'b0);
        foreach (got_beats[i]) begin
            if (got_beats[i].pix !== 200) begin
                report_value("out_beat.pix flat", got_beats[i].pix, 200);
            end
        end
        close_test("second_frame", e0);
    endtask

    task automatic reset_during_frame();
        int e0;
        e0 = errors;
        fill_image(1'b0, 0);
        for (int k = 0; k < 20; k++) begin
            send_pixel(img[k], 0);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        rst_init <= 1'b1;
        @(posedge clk);
        clear_logs();   // first reset edge, anything later is a leak
        repeat (2) @(posedge clk);
        rst_init <= 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        if (got_beats.size() != 0) report_value("out_valid after reset", got_beats.size(), 0);
        if (cmp_seen != 0) report_value("cmp_valid after reset", cmp_seen, 0);
        if (done_seen != 0) report_value("frame_done after reset", done_seen, 0);
        fill_image(1'b0, 0);
        run_frame(0, 1'b1);
        close_test("reset_mid_frame", e0);
    endtask

    initial begin
        clk          = 1'b0;
        rst_init     = 1'b1;
        in_valid     = 1'b0;
        in_pixel     = '0;
        ncyc         = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cmp_seen     = 0;
        done_seen    = 0;
        void'($urandom(32'hf5eeabcd));
        repeat (3) @(posedge clk);
        rst_init <= 1'b0;

        idle_after_reset();
        stream_back_to_back();
        stream_with_gaps();
        flat_second_frame();
        reset_during_frame();

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sim/gb_eq_asserts.sv */
// blur equivalence top assertions
module gb_eq_asserts (
    input logic                  clk,
    input logic                  rst_init,
    input logic                  out_valid,
    input logic                  frame_done,
    input logic                  mismatch,
    input gb_pkg::replay_state_t state
);

    import gb_pkg::*;

    // stream output only while a frame is in progress
    out_valid_not_idle: assert property (
        @(posedge clk) disable iff (rst_init) out_valid |-> (state != IDLE)
    ) else $error("out_valid while replay_fsm is IDLE");

    frame_done_single: assert property (
        @(posedge clk) disable iff (rst_init) frame_done |=> !frame_done
    ) else $error("frame_done high on two consecutive cycles");

    mismatch_sticky: assert property (
        @(posedge clk) disable iff (rst_init) mismatch |=> mismatch
    ) else $error("mismatch fell without reset");

endmodule

bind gb_eq_top gb_eq_asserts u_asserts (
    .clk        (clk),
    .rst_init   (rst_init),
    .out_valid  (out_valid),
    .frame_done (frame_done),
    .mismatch   (mismatch),
    .state      (u_replay.state)
);

/* logic/gb_eq_top.sv */
// blur equivalence top
// streaming engine against frame replay
module gb_eq_top (
    input  logic               clk,
    input  logic               rst_init,
    input  logic               in_valid,
    input  gb_pkg::pixel_t     in_pixel,
    output logic               out_valid,
    output gb_pkg::blur_beat_t out_beat,
    output logic               cmp_valid,
    output logic               mismatch,
    output logic [4:0]         match_count,
    output logic               frame_done,
    output logic               overflow
);

    import gb_pkg::*;

    coord_t     load_pos;
    logic       load_end;
    logic       frame_start;
    logic       rd_en;
    coord_t     rd_pos;
    logic       spec_valid;
    blur_beat_t spec_beat;
    logic       pop;
    logic       pairs_idle;
    blur_beat_t a_beat;
    blur_beat_t b_beat;
    logic       a_empty;
    logic       b_empty;
    logic       a_overflow;
    logic       b_overflow;

    // write address for the frame memory
    frame_scan u_load_scan (
        .clk       (clk),
        .rst_init  (rst_init),
        .step      (in_valid),
        .x_lo      (X_W'(0)),
        .y_lo      (Y_W'(0)),
        .x_hi      (X_W'(IMG_W - 1)),
        .y_hi      (Y_W'(IMG_H - 1)),
        .pos       (load_pos),
        .frame_end (load_end)
    );

    stencil_pipe u_stencil (
        .clk       (clk),
        .rst_init  (rst_init),
        .in_valid  (in_valid),
        .in_pixel  (in_pixel),
        .out_valid (out_valid),
        .out_beat  (out_beat)
    );

    spec_blur u_spec (
        .clk        (clk),
        .rst_init   (rst_init),
        .in_valid   (in_valid),
        .in_pixel   (in_pixel),
        .load_pos   (load_pos),
        .rd_en      (rd_en),
        .rd_pos     (rd_pos),
        .beat_valid (spec_valid),
        .beat       (spec_beat)
    );

    replay_fsm u_replay (
        .clk         (clk),
        .rst_init    (rst_init),
        .in_valid    (in_valid),
        .load_end    (load_end),
        .pairs_idle  (pairs_idle),
        .frame_start (frame_start),
        .frame_done  (frame_done),
        .rd_en       (rd_en),
        .rd_pos      (rd_pos)
    );

    beat_fifo #(.payload_t(blur_beat_t)) u_fifo_a (
        .clk       (clk),
        .rst_init  (rst_init),
        .push      (out_valid),
        .push_data (out_beat),
        .pop       (pop),
        .pop_data  (a_beat),
        .empty     (a_empty),
        .overflow  (a_overflow)
    );

    beat_fifo #(.payload_t(blur_beat_t)) u_fifo_b (
        .clk       (clk),
        .rst_init  (rst_init),
        .push      (spec_valid),
        .push_data (spec_beat),
        .pop       (pop),
        .pop_data  (b_beat),
        .empty     (b_empty),
        .overflow  (b_overflow)
    );

    eq_check u_check (
        .clk         (clk),
        .rst_init    (rst_init),
        .frame_start (frame_start),
        .a_empty     (a_empty),
        .b_empty     (b_empty),
        .a_beat      (a_beat),
        .b_beat      (b_beat),
        .pop         (pop),
        .cmp_valid   (cmp_valid),
        .mismatch    (mismatch),
        .match_count (match_count),
        .pairs_idle  (pairs_idle)
    );

    assign overflow = a_overflow | b_overflow;

endmodule

/* logic/eq_check.sv */
// paired beat comparator
module eq_check (
    input  logic               clk,
    input  logic               rst_init,
    input  logic               frame_start,
    input  logic               a_empty,
    input  logic               b_empty,
    input  gb_pkg::blur_beat_t a_beat,
    input  gb_pkg::blur_beat_t b_beat,
    output logic               pop,
    output logic               cmp_valid,
    output logic               mismatch,
    output logic [4:0]         match_count,
    output logic               pairs_idle
);

    import gb_pkg::*;

    blur_beat_t a_q;
    blur_beat_t b_q;

    assign pop        = !a_empty && !b_empty;
    assign pairs_idle = a_empty && b_empty && !cmp_valid;   // nothing queued or pending

    always_ff @(posedge clk) begin
        if (pop) begin
            a_q <= a_beat;
            b_q <= b_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            cmp_valid   <= 1'b0;
            mismatch    <= 1'b0;
            match_count <= '0;
        end else begin
            cmp_valid <= pop;
            if (frame_start) begin
                match_count <= '0;
            end else if (cmp_valid && (a_q == b_q)) begin
                match_count <= match_count + 1'b1;
            end
            if (cmp_valid && (a_q != b_q)) begin
                mismatch <= 1'b1;   // held until reset
            end
        end
    end

endmodule

/* logic/beat_fifo.sv */
// circular beat queue
module beat_fifo #(
    parameter type payload_t = gb_pkg::blur_beat_t
) (
    input  logic     clk,
    input  logic     rst_init,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     overflow
);

    import gb_pkg::*;

    payload_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    assign empty   = (count == '0);
    assign full    = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
    assign do_push = push && !full;   // drop when full
    assign do_pop  = pop && !empty;
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && full) begin
                overflow <= 1'b1;   // sticky
            end
        end
    end

endmodule

/* logic/replay_fsm.sv */
// frame load / replay / drain sequencer
module replay_fsm (
    input  logic           clk,
    input  logic           rst_init,
    input  logic           in_valid,
    input  logic           load_end,
    input  logic           pairs_idle,
    output logic           frame_start,
    output logic           frame_done,
    output logic           rd_en,
    output gb_pkg::coord_t rd_pos
);

    import gb_pkg::*;

    replay_state_t state;
    replay_state_t state_nxt;
    logic          replay_end;

    // interior centres only
    frame_scan u_replay_scan (
        .clk       (clk),
        .rst_init  (rst_init),
        .step      (rd_en),
        .x_lo      (X_W'(1)),
        .y_lo      (Y_W'(1)),
        .x_hi      (X_W'(IMG_W - 2)),
        .y_hi      (Y_W'(IMG_H - 2)),
        .pos       (rd_pos),
        .frame_end (replay_end)
    );

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (in_valid) state_nxt = LOAD;
            LOAD:    if (load_end) state_nxt = REPLAY;
            REPLAY:  if (replay_end) state_nxt = DRAIN;
            DRAIN:   if (pairs_idle) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign frame_start = (state == IDLE) && in_valid;
    assign rd_en       = (state == REPLAY);
    assign frame_done  = (state == DRAIN) && pairs_idle; // one cycle, back to IDLE

endmodule

/* logic/spec_blur.sv */
// reference blur from a full frame memory
module spec_blur (
    input  logic               clk,
    input  logic               rst_init,
    input  logic               in_valid,
    input  gb_pkg::pixel_t     in_pixel,
    input  gb_pkg::coord_t     load_pos,
    input  logic               rd_en,
    input  gb_pkg::coord_t     rd_pos,
    output logic               beat_valid,
    output gb_pkg::blur_beat_t beat
);

    import gb_pkg::*;

    pixel_t         frame_mem [IMG_H][IMG_W];
    window_t        win;
    logic [X_W-1:0] xm;
    logic [X_W-1:0] xp;
    logic [Y_W-1:0] ym;
    logic [Y_W-1:0] yp;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            frame_mem[load_pos.y][load_pos.x] <= in_pixel;
        end
    end

    // neighbours of an interior centre
    always_comb begin
        xm = rd_pos.x - 1'b1;
        xp = rd_pos.x + 1'b1;
        ym = rd_pos.y - 1'b1;
        yp = rd_pos.y + 1'b1;
        win.p00 = frame_mem[ym][xm];
        win.p01 = frame_mem[ym][rd_pos.x];
        win.p02 = frame_mem[ym][xp];
        win.p10 = frame_mem[rd_pos.y][xm];
        win.p11 = frame_mem[rd_pos.y][rd_pos.x];
        win.p12 = frame_mem[rd_pos.y][xp];
        win.p20 = frame_mem[yp][xm];
        win.p21 = frame_mem[yp][rd_pos.x];
        win.p22 = frame_mem[yp][xp];
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            beat_valid <= 1'b0;
        end else begin
            beat_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            beat.pix <= blur3x3(win);
            beat.pos <= rd_pos;
        end
    end

endmodule

/* logic/stencil_pipe.sv */
// streaming 3x3 blur
// two line buffers feeding a shifting window
module stencil_pipe (
    input  logic               clk,
    input  logic               rst_init,
    input  logic               in_valid,
    input  gb_pkg::pixel_t     in_pixel,
    output logic               out_valid,
    output gb_pkg::blur_beat_t out_beat
);

    import gb_pkg::*;

    coord_t  pos;
    pixel_t  row1_buf [IMG_W];  // previous row
    pixel_t  row2_buf [IMG_W];  // two rows up
    window_t win;
    coord_t  s1_pos;
    logic    s1_valid;
    logic    qualify;
    coord_t  centre;

    frame_scan u_scan (
        .clk       (clk),
        .rst_init  (rst_init),
        .step      (in_valid),
        .x_lo      (X_W'(0)),
        .y_lo      (Y_W'(0)),
        .x_hi      (X_W'(IMG_W - 1)),
        .y_hi      (Y_W'(IMG_H - 1)),
        .pos       (pos),
        .frame_end ()
    );

    assign qualify  = (pos.x >= X_W'(2)) && (pos.y >= Y_W'(2));
    assign centre.x = pos.x - 1'b1;
    assign centre.y = pos.y - 1'b1;

    // stage 1, the window itself is the pipeline register
    always_ff @(posedge clk) begin
        if (in_valid) begin
            row2_buf[pos.x] <= row1_buf[pos.x];
            row1_buf[pos.x] <= in_pixel;

            win.p00 <= win.p01;
            win.p01 <= win.p02;
            win.p02 <= row2_buf[pos.x];
            win.p10 <= win.p11;
            win.p11 <= win.p12;
            win.p12 <= row1_buf[pos.x];
            win.p20 <= win.p21;
            win.p21 <= win.p22;
            win.p22 <= in_pixel;

            s1_pos <= centre;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_init) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid && qualify;
            out_valid <= s1_valid;
        end
    end

    // stage 2, kernel
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            out_beat.pix <= blur3x3(win);   // win still holds the stage 1 window
            out_beat.pos <= s1_pos;
        end
    end

endmodule

/* logic/frame_scan.sv */
// raster position counter
module frame_scan (
    input  logic                 clk,
    input  logic                 rst_init,
    input  logic                 step,
    input  logic [gb_pkg::X_W-1:0] x_lo,
    input  logic [gb_pkg::Y_W-1:0] y_lo,
    input  logic [gb_pkg::X_W-1:0] x_hi,
    input  logic [gb_pkg::Y_W-1:0] y_hi,
    output gb_pkg::coord_t       pos,
    output logic                 frame_end
);

    logic row_end;

    assign row_end   = (pos.x == x_hi);
    assign frame_end = step && row_end && (pos.y == y_hi);

    always_ff @(posedge clk) begin
        if (rst_init) begin
            pos.x <= x_lo;
            pos.y <= y_lo;
        end else if (step) begin
            if (row_end) begin
                pos.x <= x_lo;
                pos.y <= (pos.y == y_hi) ? y_lo : pos.y + 1'b1; // wrap to origin
            end else begin
                pos.x <= pos.x + 1'b1;
            end
        end
    end

endmodule

/* logic/gb_pkg.sv */
// gaussian blur shared types
// image geometry, beats and the 3x3 kernel
package gb_pkg;

    localparam int IMG_W      = 8;
    localparam int IMG_H      = 6;
    localparam int X_W        = 3;
    localparam int Y_W        = 3;
    localparam int FIFO_DEPTH = 32;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    typedef logic [7:0] pixel_t;

    typedef struct packed {
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
    } coord_t;

    // pRC, row then column, p00 is top-left
    typedef struct packed {
        pixel_t p00;
        pixel_t p01;
        pixel_t p02;
        pixel_t p10;
        pixel_t p11;
        pixel_t p12;
        pixel_t p20;
        pixel_t p21;
        pixel_t p22;
    } window_t;

    typedef struct packed {
        pixel_t pix;
        coord_t pos;    // window centre
    } blur_beat_t;

    typedef enum logic [1:0] {IDLE, LOAD, REPLAY, DRAIN} replay_state_t;

    // 1 2 1 / 2 4 2 / 1 2 1, sum over 16 truncated
    function automatic pixel_t blur3x3(input window_t w);
        logic [11:0] sum;
        sum = 12'(w.p00) + 12'(w.p02) + 12'(w.p20) + 12'(w.p22);
        sum = sum + (12'(w.p01) << 1) + (12'(w.p10) << 1);
        sum = sum + (12'(w.p12) << 1) + (12'(w.p21) << 1);
        sum = sum + (12'(w.p11) << 2);
        return sum[11:4];
    endfunction

endpackage
